// ==== cache_pkg.sv ====
package cache_pkg;

    parameter int WORD_W         = 16;
    parameter int ADDR_W         = 16;
    parameter int OFFSET_W       = 2;
    parameter int WORDS_PER_LINE = 4;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
    } cpu_rsp_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } mem_req_t;

    // reads only, in request order
    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
    } mem_rsp_t;

    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REFILL,
        ST_RESPOND,       // o_rsp valid, still accepting
        ST_WRITE_THROUGH
    } ctrl_state_e;

endpackage

// ==== dcache_array.sv ====
`timescale 1ns/10ps

module dcache_array
    import cache_pkg::*;
#(
    parameter int INDEX_W = 1
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic [ADDR_W-1:0] i_lookup_addr,
    input  logic              i_word_write,
    input  logic [WORD_W-1:0] i_word_data,
    input  logic              i_touch,
    input  logic              i_fill,
    input  line_t             i_fill_line,
    output logic              o_hit,
    output logic [WORD_W-1:0] o_hit_word
);

    localparam int SETS  = 2**INDEX_W;
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    logic [SETS-1:0][1:0] valid_q;
    logic [SETS-1:0]      lru_q;    // way to replace next
    logic [TAG_W-1:0]     tag_q [SETS][2];
    line_t                data_q [SETS][2];

    logic [INDEX_W-1:0]  set_idx;
    logic [TAG_W-1:0]    look_tag;
    logic [OFFSET_W-1:0] offset;
    logic [1:0]          hit_way;
    logic                hit_sel;
    logic                victim;

    assign set_idx  = i_lookup_addr[OFFSET_W +: INDEX_W];
    assign look_tag = i_lookup_addr[ADDR_W-1 -: TAG_W];
    assign offset   = i_lookup_addr[OFFSET_W-1:0];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_way[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == look_tag);
        end
    end

    assign hit_sel    = hit_way[1];
    assign o_hit      = |hit_way;
    assign o_hit_word = data_q[set_idx][hit_sel][offset];

    // empty way 0, then empty way 1, then lru
    assign victim = !valid_q[set_idx][0] ? 1'b0 :
                    !valid_q[set_idx][1] ? 1'b1 : lru_q[set_idx];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else if (i_fill) begin
            valid_q[set_idx][victim] <= 1'b1;
            lru_q[set_idx]           <= ~victim;
        end else if (i_touch) begin
            lru_q[set_idx] <= ~hit_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_q[set_idx][victim]  <= look_tag;
            data_q[set_idx][victim] <= i_fill_line;
        end else if (i_word_write) begin
            data_q[set_idx][hit_sel][offset] <= i_word_data; // write hit only
        end
    end

    // fills only happen on a miss, so a block never lands in both ways
    a_one_way_hit: assert property (@(posedge clk) disable iff (!reset_n)
        !(hit_way[0] && hit_way[1]));

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/10ps

module dcache_ctrl
    import cache_pkg::*;
#(
    parameter int INDEX_W = 1
) (
    input  logic              clk,
    input  logic              reset_n,
    input  cpu_req_t          i_req,
    input  logic              i_hit,
    input  logic [WORD_W-1:0] i_hit_word,
    input  logic              i_line_done,
    input  line_t             i_line,
    input  logic              i_write_issued,
    output logic              o_ready,
    output cpu_rsp_t          o_rsp,
    output logic [ADDR_W-1:0] o_lookup_addr,
    output logic              o_word_write,
    output logic [WORD_W-1:0] o_word_data,
    output logic              o_touch,
    output logic              o_refill_start,
    output logic [ADDR_W-1:0] o_refill_base,
    output logic              o_write_start,
    output logic [ADDR_W-1:0] o_write_addr,
    output logic [WORD_W-1:0] o_write_data,
    output logic [15:0]       o_hit_count,
    output logic [15:0]       o_miss_count
);

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic [ADDR_W-1:0] req_addr_q;
    logic [WORD_W-1:0] req_wdata_q;
    logic [WORD_W-1:0] rsp_data_q;
    logic              accept;
    logic              rd_hit;
    logic [TAG_W-1:0]  req_tag;
    logic [INDEX_W-1:0] req_set;

    assign o_ready = (state_q == ST_IDLE) || (state_q == ST_RESPOND);
    assign accept  = i_req.valid && o_ready;
    assign rd_hit  = accept && !i_req.we && i_hit;

    // held address once the request leaves the accepting states
    assign o_lookup_addr = o_ready ? i_req.addr : req_addr_q;

    assign req_tag       = i_req.addr[ADDR_W-1 -: TAG_W];
    assign req_set       = i_req.addr[OFFSET_W +: INDEX_W];
    assign o_refill_base = {req_tag, req_set, {OFFSET_W{1'b0}}};

    assign o_touch        = accept && i_hit;
    assign o_word_write   = accept && i_req.we && i_hit;
    assign o_word_data    = i_req.wdata;
    assign o_refill_start = accept && !i_req.we && !i_hit;
    assign o_write_start  = accept && i_req.we;
    assign o_write_addr   = req_addr_q;
    assign o_write_data   = req_wdata_q;

    assign o_rsp.valid = (state_q == ST_RESPOND);
    assign o_rsp.data  = rsp_data_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE, ST_RESPOND: begin
                if (!accept) begin
                    state_d = ST_IDLE;
                end else if (i_req.we) begin
                    state_d = ST_WRITE_THROUGH;
                end else if (i_hit) begin
                    state_d = ST_RESPOND;
                end else begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (i_line_done) state_d = ST_RESPOND;
            end
            ST_WRITE_THROUGH: begin
                if (i_write_issued) state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q      <= ST_IDLE;
            o_hit_count  <= '0;
            o_miss_count <= '0;
        end else begin
            state_q <= state_d;
            if (accept && i_hit) o_hit_count <= o_hit_count + 16'd1;
            if (accept && !i_hit) o_miss_count <= o_miss_count + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q  <= i_req.addr;
            req_wdata_q <= i_req.wdata;
        end
        if (rd_hit) begin
            rsp_data_q <= i_hit_word;
        end else if (state_q == ST_REFILL && i_line_done) begin
            rsp_data_q <= i_line[req_addr_q[OFFSET_W-1:0]]; // requested word of the new block
        end
    end

    // a response only follows an accepted read or a finished refill
    a_rsp_needs_read: assert property (@(posedge clk) disable iff (!reset_n)
        (o_ready && !(i_req.valid && !i_req.we)) |=> !o_rsp.valid);

endmodule

// ==== mem_link.sv ====
`timescale 1ns/10ps

module mem_link
    import cache_pkg::*;
#(
    parameter int MEM_CREDITS = 2
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_refill_start,
    input  logic [ADDR_W-1:0] i_refill_base,
    input  logic              i_write_start,
    input  logic [ADDR_W-1:0] i_write_addr,
    input  logic [WORD_W-1:0] i_write_data,
    input  mem_rsp_t          i_mem_rsp,
    input  logic              i_mem_credit,
    output mem_req_t          o_mem_req,
    output logic              o_line_done,
    output line_t             o_line,
    output logic              o_write_issued
);

    localparam int CNT_W = $clog2(MEM_CREDITS + 1);
    localparam logic [OFFSET_W:0] LINE_END = (OFFSET_W + 1)'(WORDS_PER_LINE);

    logic [CNT_W-1:0]           credit_q;
    logic [OFFSET_W:0]          req_idx_q;   // LINE_END when no refill
    logic [OFFSET_W:0]          rsp_idx_q;
    logic [ADDR_W-OFFSET_W-1:0] blk_q;
    logic                       wr_pend_q;
    line_t                      line_q;

    logic have_credit;
    logic rd_want;
    logic rd_issue;
    logic wr_issue;
    logic issue;

    assign have_credit = (credit_q != '0);
    assign rd_want     = (req_idx_q < LINE_END);
    assign rd_issue    = rd_want && have_credit;
    assign wr_issue    = wr_pend_q && !rd_want && have_credit;
    assign issue       = rd_issue || wr_issue;

    assign o_mem_req.valid = issue;
    assign o_mem_req.we    = wr_issue;
    assign o_mem_req.addr  = wr_issue ? i_write_addr : {blk_q, req_idx_q[OFFSET_W-1:0]};
    assign o_mem_req.wdata = i_write_data;
    assign o_write_issued  = wr_issue;
    assign o_line          = line_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            credit_q    <= CNT_W'(MEM_CREDITS);
            req_idx_q   <= LINE_END;
            rsp_idx_q   <= LINE_END;
            wr_pend_q   <= 1'b0;
            o_line_done <= 1'b0;
        end else begin
            case ({issue, i_mem_credit})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q; // both or neither cancel
            endcase

            if (i_refill_start) begin
                req_idx_q <= '0;
                rsp_idx_q <= '0;
            end else begin
                if (rd_issue) req_idx_q <= req_idx_q + 1'b1;
                if (i_mem_rsp.valid) rsp_idx_q <= rsp_idx_q + 1'b1;
            end

            if (i_write_start) begin
                wr_pend_q <= 1'b1;
            end else if (wr_issue) begin
                wr_pend_q <= 1'b0;
            end

            o_line_done <= i_mem_rsp.valid && (rsp_idx_q == LINE_END - 1'b1);
        end
    end

    always_ff @(posedge clk) begin
        if (i_refill_start) blk_q <= i_refill_base[ADDR_W-1:OFFSET_W];
        if (i_mem_rsp.valid) line_q[rsp_idx_q[OFFSET_W-1:0]] <= i_mem_rsp.data;
    end

    // a request at zero credit would wrap the counter
    a_no_req_without_credit: assert property (@(posedge clk) disable iff (!reset_n)
        (credit_q == '0 && !i_mem_credit) |=> (credit_q == '0));

    // memory returns no more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
        credit_q <= CNT_W'(MEM_CREDITS));

    a_rsp_outstanding: assert property (@(posedge clk) disable iff (!reset_n)
        i_mem_rsp.valid |-> (req_idx_q > rsp_idx_q));

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top
    import cache_pkg::*;
#(
    parameter int INDEX_W     = 1,
    parameter int MEM_CREDITS = 2
) (
    input  logic     clk,
    input  logic     reset_n,
    input  cpu_req_t i_req,
    input  mem_rsp_t i_mem_rsp,
    input  logic     i_mem_credit,
    output logic     o_ready,
    output cpu_rsp_t o_rsp,
    output mem_req_t o_mem_req,
    output logic [15:0] o_hit_count,
    output logic [15:0] o_miss_count
);

    logic              hit;
    logic [WORD_W-1:0] hit_word;
    logic [ADDR_W-1:0] lookup_addr;
    logic              word_write;
    logic [WORD_W-1:0] word_data;
    logic              touch;
    logic              refill_start;
    logic [ADDR_W-1:0] refill_base;
    logic              write_start;
    logic [ADDR_W-1:0] write_addr;
    logic [WORD_W-1:0] write_data;
    logic              line_done;   // also the array's fill strobe
    line_t             line;
    logic              write_issued;

    dcache_ctrl #(.INDEX_W(INDEX_W)) ctrl0 (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_req          (i_req),
        .i_hit          (hit),
        .i_hit_word     (hit_word),
        .i_line_done    (line_done),
        .i_line         (line),
        .i_write_issued (write_issued),
        .o_ready        (o_ready),
        .o_rsp          (o_rsp),
        .o_lookup_addr  (lookup_addr),
        .o_word_write   (word_write),
        .o_word_data    (word_data),
        .o_touch        (touch),
        .o_refill_start (refill_start),
        .o_refill_base  (refill_base),
        .o_write_start  (write_start),
        .o_write_addr   (write_addr),
        .o_write_data   (write_data),
        .o_hit_count    (o_hit_count),
        .o_miss_count   (o_miss_count)
    );

    dcache_array #(.INDEX_W(INDEX_W)) array0 (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_lookup_addr (lookup_addr),
        .i_word_write  (word_write),
        .i_word_data   (word_data),
        .i_touch       (touch),
        .i_fill        (line_done),
        .i_fill_line   (line),
        .o_hit         (hit),
        .o_hit_word    (hit_word)
    );

    mem_link #(.MEM_CREDITS(MEM_CREDITS)) link0 (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_refill_start (refill_start),
        .i_refill_base  (refill_base),
        .i_write_start  (write_start),
        .i_write_addr   (write_addr),
        .i_write_data   (write_data),
        .i_mem_rsp      (i_mem_rsp),
        .i_mem_credit   (i_mem_credit),
        .o_mem_req      (o_mem_req),
        .o_line_done    (line_done),
        .o_line         (line),
        .o_write_issued (write_issued)
    );

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/10ps

module tb_dcache
    import cache_pkg::*;
;

    localparam int MEM_CREDITS = 2;
    localparam int N_RANDOM    = 300;
    localparam int N_REQ       = 10 + N_RANDOM;
    localparam int TIMEOUT_NS  = (N_REQ * 60 + 5) * 4;  // 60 cycles per request plus reset

    logic        clk     = 1'b0;
    logic        reset_n = 1'b0;
    cpu_req_t    req     = '0;
    mem_rsp_t    mem_rsp = '0;
    logic        mem_credit = 1'b0;
    logic        ready;
    cpu_rsp_t    rsp;
    mem_req_t    mem_req;
    logic [15:0] hit_count;
    logic [15:0] miss_count;

    logic [15:0] shadow [65536];
    logic [31:0] stim_lfsr = 32'haac3_aa8b;
    logic [31:0] mem_lfsr  = 32'haac3_aa8b;

    // reference cache state, 2 sets x 2 ways
    logic [12:0] ref_tag [2][2];
    bit          ref_valid [2][2];
    bit          ref_mru [2];
    logic [15:0] exp_hits   = '0;
    logic [15:0] exp_misses = '0;

    logic [15:0] rd_addrs[$];
    logic [15:0] refill_addrs[$];
    logic [15:0] wr_addrs[$];
    logic [15:0] wr_datas[$];
    bit          slot_we[$];
    logic [15:0] slot_addr[$];
    int          slot_wait[$];
    bit          data_sent = 1'b0;
    int          avail = MEM_CREDITS;
    logic [15:0] chk_addr;

    always #2 clk = ~clk;

    dcache_top dut0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_req        (req),
        .i_mem_rsp    (mem_rsp),
        .i_mem_credit (mem_credit),
        .o_ready      (ready),
        .o_rsp        (rsp),
        .o_mem_req    (mem_req),
        .o_hit_count  (hit_count),
        .o_miss_count (miss_count)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic expect_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            fail_now($sformatf("mismatch at time %0t: %s got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_counts();
        expect_val("o_hit_count", 32'(hit_count), 32'(exp_hits));
        expect_val("o_miss_count", 32'(miss_count), 32'(exp_misses));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] draw_bits(inout logic [31:0] s, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v = {v[30:0], s[0]};
        end
        return v;
    endfunction

    // updates the reference state, returns the expected hit
    function automatic bit predict_hit(input logic [15:0] addr, input bit we);
        int          s_idx;
        int          way;
        bit          hit;
        logic [12:0] tag;
        s_idx = int'(addr[2]);
        tag   = addr[15:3];
        hit   = 1'b0;
        way   = 0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[s_idx][w] && ref_tag[s_idx][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit && !we) begin  // read miss allocates, write miss does not
            if (!ref_valid[s_idx][0]) way = 0;
            else if (!ref_valid[s_idx][1]) way = 1;
            else way = ref_mru[s_idx] ? 0 : 1;
            ref_valid[s_idx][way] = 1'b1;
            ref_tag[s_idx][way]   = tag;
        end
        if (hit || !we) ref_mru[s_idx] = (way == 1);
        return hit;
    endfunction

    // called on a rising edge, returns on the edge where the access is complete
    task automatic do_access(input bit we, input logic [15:0] addr, input logic [15:0] wdata,
                             output bit dut_hit, output logic [15:0] rdata);
        logic [15:0] hits_before;
        bit          exp_hit;
        req <= '{valid: 1'b1, we: we, addr: addr, wdata: wdata};
        do @(posedge clk); while (!ready);
        req.valid <= 1'b0;
        hits_before = hit_count;
        exp_hit = predict_hit(addr, we);
        if (exp_hit) exp_hits = exp_hits + 16'd1;
        else exp_misses = exp_misses + 16'd1;
        if (we) begin
            wr_addrs.push_back(addr);
            wr_datas.push_back(wdata);
            do @(posedge clk); while (!ready);
            rdata = '0;
        end else begin
            rd_addrs.push_back(addr);
            if (!exp_hit) begin
                for (int i = 0; i < 4; i++) refill_addrs.push_back({addr[15:2], 2'(i)});
            end
            do @(posedge clk); while (!rsp.valid);
            rdata = rsp.data;
        end
        dut_hit = (hit_count != hits_before);
    endtask

    // memory: in-order slots, data then credit after 1 to 4 cycles
    always @(posedge clk) begin
        mem_rsp    <= '0;
        mem_credit <= 1'b0;
        if (!reset_n) begin
            slot_we.delete();
            slot_addr.delete();
            slot_wait.delete();
            data_sent = 1'b0;
        end else begin
            if (mem_req.valid) begin
                slot_we.push_back(mem_req.we);
                slot_addr.push_back(mem_req.addr);
                slot_wait.push_back(int'(draw_bits(mem_lfsr, 2)) + 1);
            end
            if (slot_we.size() != 0) begin
                if (slot_wait[0] > 0) begin
                    slot_wait[0] = slot_wait[0] - 1;
                end else if (!slot_we[0] && !data_sent) begin
                    mem_rsp   <= '{valid: 1'b1, data: shadow[slot_addr[0]]};
                    data_sent = 1'b1;
                end else begin
                    mem_credit <= 1'b1;
                    slot_we.pop_front();
                    slot_addr.pop_front();
                    slot_wait.pop_front();
                    data_sent = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (reset_n) begin
            if (rsp.valid) begin
                assert (rd_addrs.size() != 0) else fail_now("read response with no read pending");
                chk_addr = rd_addrs.pop_front();
                expect_val("o_rsp.data", 32'(rsp.data), 32'(shadow[chk_addr]));
                check_counts();
            end
            if (mem_req.valid) begin
                assert (avail > 0) else fail_now("memory request issued with no credit left");
                if (mem_req.we) begin
                    assert (wr_addrs.size() != 0) else fail_now("memory write with no write pending");
                    chk_addr = wr_addrs.pop_front();
                    expect_val("o_mem_req.addr", 32'(mem_req.addr), 32'(chk_addr));
                    expect_val("o_mem_req.wdata", 32'(mem_req.wdata), 32'(wr_datas.pop_front()));
                    shadow[mem_req.addr] = mem_req.wdata;
                    check_counts();
                end else begin
                    assert (refill_addrs.size() != 0) else fail_now("refill read with no miss pending");
                    chk_addr = refill_addrs.pop_front();
                    expect_val("o_mem_req.addr", 32'(mem_req.addr), 32'(chk_addr));
                end
            end
            avail = avail - (mem_req.valid ? 1 : 0) + (mem_credit ? 1 : 0);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        fail_now("watchdog expired before the tests finished");
    end

    initial begin
        bit          h;
        logic [15:0] d;
        logic [31:0] r_we;
        logic [31:0] r_tag;
        logic [31:0] r_set;
        logic [31:0] r_off;
        logic [31:0] r_data;
        logic [15:0] addr;
        for (int a = 0; a < 65536; a++) shadow[a] = 16'(a) ^ 16'h5a5a;

        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        expect_val("o_ready", 32'(ready), 32'd1);
        expect_val("o_rsp.valid", 32'(rsp.valid), 32'd0);
        expect_val("o_mem_req.valid", 32'(mem_req.valid), 32'd0);
        expect_val("o_hit_count", 32'(hit_count), 32'd0);
        expect_val("o_miss_count", 32'(miss_count), 32'd0);

        // set 0: A, B, A, C leaves B as the victim
        do_access(1'b0, 16'h0100, 16'h0, h, d);
        expect_val("hit on first A", 32'(h), 32'd0);
        do_access(1'b0, 16'h0180, 16'h0, h, d);
        expect_val("hit on first B", 32'(h), 32'd0);
        do_access(1'b0, 16'h0100, 16'h0, h, d);
        expect_val("hit on second A", 32'(h), 32'd1);
        do_access(1'b0, 16'h0110, 16'h0, h, d);
        expect_val("hit on C", 32'(h), 32'd0);
        do_access(1'b0, 16'h0100, 16'h0, h, d);
        expect_val("hit on A after C", 32'(h), 32'd1);
        do_access(1'b0, 16'h0180, 16'h0, h, d);
        expect_val("hit on B after C", 32'(h), 32'd0);

        do_access(1'b1, 16'h0101, 16'hbeef, h, d);   // write hit
        expect_val("hit on write to A", 32'(h), 32'd1);
        do_access(1'b0, 16'h0101, 16'h0, h, d);
        expect_val("o_rsp.data after write hit", 32'(d), 32'hbeef);
        do_access(1'b1, 16'h0404, 16'h1234, h, d);   // write miss, no allocate
        do_access(1'b0, 16'h0404, 16'h0, h, d);
        expect_val("hit on read after write miss", 32'(h), 32'd0);

        // three tags over both sets
        for (int i = 0; i < N_RANDOM; i++) begin
            r_we   = draw_bits(stim_lfsr, 2);
            r_tag  = draw_bits(stim_lfsr, 2) % 3;
            r_set  = draw_bits(stim_lfsr, 1);
            r_off  = draw_bits(stim_lfsr, 2);
            r_data = draw_bits(stim_lfsr, 16);
            addr   = {13'h0040 + r_tag[12:0], r_set[0], r_off[1:0]};
            do_access(r_we == 0, addr, r_data[15:0], h, d);
        end

        if (rd_addrs.size() == 0 && refill_addrs.size() == 0 && wr_addrs.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_now("requests still pending at the end of the run");
        end
    end

endmodule

// ==== sources.f ====
cache_pkg.sv
dcache_array.sv
dcache_ctrl.sv
mem_link.sv
dcache_top.sv
tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_dcache -f sources.f &&
./obj_dir/Vtb_dcache | tee /dev/stderr | grep -qx "TESTS PASSED" &&
echo "simulation ok" || { echo "simulation failed"; exit 1; }
